// ==== Bender.yml ====
package:
  name: imuldiv

sources:
  # shared package first, then RTL bottom-up
  - common/imuldiv_pkg.sv
  - rtl/imuldiv_ctrl.sv
  - rtl/imuldiv_sign_unit.sv
  - rtl/imuldiv_mul_dpath.sv
  - rtl/imuldiv_div_dpath.sv
  - rtl/imuldiv_iterative.sv

  # verification sources, top module imuldiv_tb
  - target: test
    files:
      - test/imuldiv_properties.sv
      - test/imuldiv_tb.sv

// ==== common/imuldiv_pkg.sv ====
//----------------------------------------
// imuldiv shared definitions
// widths, opcodes, request/response and datapath control types
//----------------------------------------

package imuldiv_pkg;

  //----------------------------------------
  // widths
  //----------------------------------------

  // operand width, also the number of iteration steps
  localparam int xlen = 32;
  // full product / {rem, quo} result width
  localparam int dlen = 64;
  // step counter width, counts xlen-1 down to 0
  localparam int cnt_w = 5;

  //----------------------------------------
  // opcodes and states
  //----------------------------------------

  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } ctrl_state_e;

  //----------------------------------------
  // bus payloads
  //----------------------------------------

  typedef struct packed {
    muldiv_op_e      op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } muldiv_req_t;

  // div results carry rem in the upper half, quo in the lower half
  typedef struct packed {
    logic [dlen-1:0] result;
  } muldiv_resp_t;

  // per-cycle strobes from control to the datapaths
  typedef struct packed {
    logic load;
    logic step;
    logic fix;
  } dpath_ctrl_t;

endpackage

// ==== filelist.f ====
common/imuldiv_pkg.sv
rtl/imuldiv_ctrl.sv
rtl/imuldiv_sign_unit.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_div_dpath.sv
rtl/imuldiv_iterative.sv
test/imuldiv_properties.sv
test/imuldiv_tb.sv

// ==== rtl/imuldiv_ctrl.sv ====
//----------------------------------------
// imuldiv control FSM
// sequences load, 32 calc steps, sign fix and response handshake
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_ctrl (
  input  logic                     clk,
  input  logic                     reset,

  input  logic                     req_val,
  output logic                     req_rdy,

  output logic                     resp_val,
  input  logic                     resp_rdy,

  output imuldiv_pkg::dpath_ctrl_t ctrl
);

  import imuldiv_pkg::*;

  ctrl_state_e      state;
  ctrl_state_e      state_next;
  logic [cnt_w-1:0] cnt;

  logic req_go;
  logic resp_go;
  logic last_step;

  //----------------------------------------
  // handshake
  //----------------------------------------

  // both depend on state only, so they are never high together
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last_step = (cnt == '0);

  //----------------------------------------
  // next state
  //----------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req_go) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // counter hits zero on the 32nd calc cycle
        if (last_step) begin
          state_next = st_fix;
        end
      end
      st_fix: begin
        state_next = st_done;
      end
      st_done: begin
        // hold result until the consumer takes it
        if (resp_go) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        // reload for a fresh run of xlen steps
        cnt <= cnt_w'(xlen - 1);
      end else if (state == st_calc) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  //----------------------------------------
  // datapath strobes
  //----------------------------------------

  always_comb begin
    ctrl      = '0;
    ctrl.load = req_go;
    ctrl.step = (state == st_calc);
    ctrl.fix  = (state == st_fix);
  end

endmodule

// ==== rtl/imuldiv_div_dpath.sv ====
//----------------------------------------
// imuldiv restoring divider
// unsigned 32-bit quotient and remainder over 32 steps
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_div_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::dpath_ctrl_t     ctrl,
  input  logic [imuldiv_pkg::xlen-1:0] mag_a,
  input  logic [imuldiv_pkg::xlen-1:0] mag_b,
  output logic [imuldiv_pkg::xlen-1:0] quo,
  output logic [imuldiv_pkg::xlen-1:0] rem
);

  import imuldiv_pkg::*;

  logic [xlen-1:0] rem_q;
  // dividend shifts out the top while quotient bits fill the bottom
  logic [xlen-1:0] quo_q;
  logic [xlen-1:0] dvsr_q;

  // shifted partial remainder, one bit wider than xlen
  logic [xlen:0]   rem_shift;
  // trial difference with an extra bit for the borrow
  logic [xlen+1:0] diff;
  logic            diff_neg;

  //----------------------------------------
  // trial subtract
  //----------------------------------------

  assign rem_shift = {rem_q, quo_q[xlen-1]};
  assign diff      = {1'b0, rem_shift} - {2'b00, dvsr_q};
  assign diff_neg  = diff[xlen+1];

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      dvsr_q <= mag_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rem_q <= '0;
      quo_q <= '0;
    end else if (ctrl.load) begin
      rem_q <= '0;
      quo_q <= mag_a;
    end else if (ctrl.step) begin
      if (diff_neg) begin
        // restore, remainder is just the shifted value
        rem_q <= rem_shift[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end else begin
        // divisor of zero always lands here, giving all-ones quotient
        rem_q <= diff[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end
    end
  end

  //----------------------------------------
  // outputs
  //----------------------------------------

  assign quo = quo_q;
  assign rem = rem_q;

endmodule

// ==== rtl/imuldiv_iterative.sv ====
//----------------------------------------
// imuldiv iterative mul/div unit
// val/rdy wrapper around control, sign unit and both datapaths
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_iterative (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req,

  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::muldiv_resp_t resp
);

  import imuldiv_pkg::*;

  dpath_ctrl_t     ctrl;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic [dlen-1:0] prod;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;

  // FSM and handshake
  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl)
  );

  // magnitudes out, corrected result back
  imuldiv_sign_unit u_sign (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .req   (req),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .prod  (prod),
    .quo   (quo),
    .rem   (rem),
    .resp  (resp)
  );

  imuldiv_mul_dpath u_mul (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .prod  (prod)
  );

  imuldiv_div_dpath u_div (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .quo   (quo),
    .rem   (rem)
  );

endmodule

// ==== rtl/imuldiv_mul_dpath.sv ====
//----------------------------------------
// imuldiv shift-and-add multiplier
// unsigned 32x32 product over 32 steps
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_mul_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::dpath_ctrl_t     ctrl,
  input  logic [imuldiv_pkg::xlen-1:0] mag_a,
  input  logic [imuldiv_pkg::xlen-1:0] mag_b,
  output logic [imuldiv_pkg::dlen-1:0] prod
);

  import imuldiv_pkg::*;

  //----------------------------------------
  // operand and accumulator registers
  //----------------------------------------

  // multiplicand widened so it can shift left xlen times
  logic [dlen-1:0] mcand_q;
  logic [xlen-1:0] mplier_q;
  logic [dlen-1:0] acc_q;
  logic [dlen-1:0] acc_sum;

  // partial product add, gated by the current multiplier bit
  assign acc_sum = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      mcand_q  <= {{(dlen - xlen){1'b0}}, mag_a};
      mplier_q <= mag_b;
    end else if (ctrl.step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // accumulator starts clean so prod is defined before the first op
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (ctrl.load) begin
      acc_q <= '0;
    end else if (ctrl.step) begin
      acc_q <= acc_sum;
    end
  end

  //----------------------------------------
  // output
  //----------------------------------------

  // after the last step this is the full unsigned product
  assign prod = acc_q;

endmodule

// ==== rtl/imuldiv_sign_unit.sv ====
//----------------------------------------
// imuldiv sign handling
// operand magnitudes in, sign-corrected result register out
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_sign_unit (
  input  logic                              clk,
  input  logic                              reset,
  input  imuldiv_pkg::dpath_ctrl_t          ctrl,
  input  imuldiv_pkg::muldiv_req_t          req,
  output logic [imuldiv_pkg::xlen-1:0]      mag_a,
  output logic [imuldiv_pkg::xlen-1:0]      mag_b,
  input  logic [imuldiv_pkg::dlen-1:0]      prod,
  input  logic [imuldiv_pkg::xlen-1:0]      quo,
  input  logic [imuldiv_pkg::xlen-1:0]      rem,
  output imuldiv_pkg::muldiv_resp_t         resp
);

  import imuldiv_pkg::*;

  muldiv_op_e op_q;
  logic       is_signed;
  logic       neg_res_q;
  logic       neg_rem_q;
  logic       is_div_q;

  // unsigned opcodes pass operands through untouched
  assign is_signed = (req.op == op_mul) || (req.op == op_div);
  assign mag_a     = (is_signed && req.a[xlen-1]) ? -req.a : req.a;
  assign mag_b     = (is_signed && req.b[xlen-1]) ? -req.b : req.b;
  assign is_div_q  = (op_q == op_div) || (op_q == op_divu);

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q      <= op_mul;
      neg_res_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end else if (ctrl.load) begin
      op_q      <= req.op;
      // product / quotient negative when signs differ
      neg_res_q <= is_signed && (req.a[xlen-1] ^ req.b[xlen-1]);
      // remainder follows the dividend
      neg_rem_q <= is_signed && req.a[xlen-1];
    end
  end

  // result register, held through back-pressure in st_done
  always_ff @(posedge clk) begin
    if (ctrl.fix) begin
      if (is_div_q) begin
        resp.result[dlen-1:xlen] <= neg_rem_q ? -rem : rem;
        resp.result[xlen-1:0]    <= neg_res_q ? -quo : quo;
      end else begin
        resp.result <= neg_res_q ? -prod : prod;
      end
    end
  end

endmodule

// ==== test/imuldiv_properties.sv ====
//----------------------------------------
// imuldiv handshake properties
// bound into the control FSM
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_properties (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_rdy,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input imuldiv_pkg::ctrl_state_e state
);

  import imuldiv_pkg::*;

  // no response in the first cycle out of reset
  resp_low_after_reset: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else $error("resp_val high in the first cycle after reset");

  // ready for a request and holding a response are exclusive
  rdy_val_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  // a stalled response may not be withdrawn
  resp_held_on_stall: assert property (
    @(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> resp_val
  ) else $error("resp_val dropped while resp_rdy was low");

  // calc phase lasts exactly xlen cycles before the fix cycle
  calc_length: assert property (
    @(posedge clk) disable iff (reset) $rose(state == st_calc) |-> ##(xlen) (state == st_fix)
  ) else $error("calculation phase did not last xlen cycles");

endmodule

bind imuldiv_ctrl imuldiv_properties u_props (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .state    (state)
);

// ==== test/imuldiv_tb.sv ====
//----------------------------------------
// imuldiv testbench
// replays vectors from the data file with response back-pressure
//----------------------------------------

`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_pkg::*;

  // 32 calc cycles plus the fix cycle
  localparam int calc_latency = xlen + 1;
  // edges spent per vector without any extra response delay
  localparam int vector_edges = 36;

  logic         clk;
  logic         reset;
  logic         req_val;
  logic         req_rdy;
  muldiv_req_t  req;
  logic         resp_val;
  logic         resp_rdy;
  muldiv_resp_t resp;

  // vector storage, filled before reset is released
  string           vec_name[$];
  muldiv_req_t     vec_req[$];
  int              vec_delay[$];
  logic [dlen-1:0] vec_exp[$];

  int max_delay   = 0;
  int cycle       = 0;
  int cycle_limit = 0;

  imuldiv_iterative i_imuldiv_iterative (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  //----------------------------------------
  // clock, cycle count and timeout
  //----------------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stable at every falling edge, where the checks sample
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycle < cycle_limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    stop_with_failure();
  end

  //----------------------------------------
  // error reporting
  //----------------------------------------

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [dlen-1:0] expected,
                                 input logic [dlen-1:0] actual);
    $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("error: %s", what);
    stop_with_failure();
  endtask

  //----------------------------------------
  // data file
  //----------------------------------------

  // columns: name, opcode, a, b, resp_rdy delay, expected {hi, lo}
  task automatic read_vectors();
    int              fd;
    int              fields;
    string           line;
    string           name;
    logic [1:0]      op_bits;
    logic [xlen-1:0] a_bits;
    logic [xlen-1:0] b_bits;
    int              delay_val;
    logic [dlen-1:0] exp_bits;
    muldiv_req_t     entry;
    fd = $fopen("test/imuldiv_testdata.txt", "r");
    assert (fd != 0) else report_problem("could not open test/imuldiv_testdata.txt");
    while ($fgets(line, fd) != 0) begin
      // blank lines and # comments carry no vector
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %d %h", name, op_bits, a_bits, b_bits,
                         delay_val, exp_bits);
        assert (fields == 6) else report_problem({"malformed vector line: ", line});
        entry.op = muldiv_op_e'(op_bits);
        entry.a  = a_bits;
        entry.b  = b_bits;
        vec_name.push_back(name);
        vec_req.push_back(entry);
        vec_delay.push_back(delay_val);
        vec_exp.push_back(exp_bits);
        if (delay_val > max_delay) begin
          max_delay = delay_val;
        end
      end
    end
    $fclose(fd);
    assert (vec_name.size() > 0) else report_problem("data file holds no vectors");
  endtask

  //----------------------------------------
  // one request/response transaction
  //----------------------------------------

  // entered on a rising edge, returns on the response transfer edge
  task automatic run_vector(input string name, input muldiv_req_t vreq, input int delay,
                            input logic [dlen-1:0] expected);
    logic [dlen-1:0] held;
    int              accept_cycle;
    int              latency;
    req     <= vreq;
    req_val <= 1'b1;
    // unit is idle, so the very next edge must accept
    @(negedge clk);
    assert (req_rdy && !resp_val) else report_problem({"request not accepted at once: ", name});
    @(posedge clk);
    req_val <= 1'b0;
    @(negedge clk);
    accept_cycle = cycle;
    while (!resp_val) begin
      assert (!req_rdy) else report_problem({"req_rdy high while busy: ", name});
      @(negedge clk);
    end
    latency = cycle - accept_cycle;
    assert (latency == calc_latency) else report_mismatch({name, "_latency"}, calc_latency,
                                                          latency);
    held = resp.result;
    assert (held == expected) else report_mismatch(name, expected, held);
    // back-pressure, response and handshake frozen
    repeat (delay) begin
      @(negedge clk);
      assert (resp_val && !req_rdy) else report_problem({"handshake moved under stall: ", name});
      assert (resp.result == held) else report_mismatch({name, "_held"}, held, resp.result);
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    @(posedge clk);
    resp_rdy <= 1'b0;
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------

  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req      = '0;
    resp_rdy = 1'b0;
    read_vectors();
    cycle_limit = vec_name.size() * (vector_edges + max_delay) + 20;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (req_rdy && !resp_val) else report_problem("handshake not idle after reset");
    @(posedge clk);
    foreach (vec_name[i]) begin
      run_vector(vec_name[i], vec_req[i], vec_delay[i], vec_exp[i]);
    end
    // req_rdy back in the cycle after the last transfer
    @(negedge clk);
    assert (req_rdy && !resp_val) else report_problem("unit not idle after last response");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== test/imuldiv_testdata.txt ====
# name op(0 mul,1 mulu,2 div,3 divu) a b resp_rdy_delay expected
# expected is the 64-bit product, or {remainder, quotient} for divides
mul_small          0 00000007 00000006 0 000000000000002a
mul_neg_pos        0 fffffffd 00000005 1 fffffffffffffff1
mul_neg_neg        0 fffffffd fffffff9 0 0000000000000015
mulu_same_bits     1 fffffffd 00000005 0 00000004fffffff1
mul_zero           0 00000000 80000000 2 0000000000000000
mul_min_min        0 80000000 80000000 0 4000000000000000
mulu_max_max       1 ffffffff ffffffff 4 fffffffe00000001
mul_m1_m1          0 ffffffff ffffffff 0 0000000000000001
mul_min_m1         0 80000000 ffffffff 1 0000000080000000
mul_large          0 12345678 00010000 0 0000123456780000
mulu_min_two       1 80000000 00000002 0 0000000100000000
mul_min_two        0 80000000 00000002 3 ffffffff00000000
divu_basic         3 00000064 00000007 0 000000020000000e
div_neg_dividend   2 ffffff9c 00000007 3 fffffffefffffff2
div_neg_divisor    2 00000064 fffffff9 0 00000002fffffff2
div_neg_neg        2 ffffff9c fffffff9 0 fffffffe0000000e
divu_same_bits     3 ffffff9c 00000007 1 0000000224924916
div_min_m1         2 80000000 ffffffff 0 0000000080000000
divu_min_m1        3 80000000 ffffffff 0 8000000000000000
div_by_zero_pos    2 00000064 00000000 0 00000064ffffffff
div_by_zero_neg    2 ffffff9c 00000000 2 ffffff9c00000001
divu_by_zero       3 ffffffff 00000000 0 ffffffffffffffff
div_small_big      2 00000003 00000064 0 0000000300000000
div_min_two        2 80000000 00000002 4 00000000c0000000
divu_max_one       3 ffffffff 00000001 0 00000000ffffffff
div_exact_neg      2 fffffff0 00000004 1 00000000fffffffc
